/* video_pkg.sv */
package video_pkg;

    // one palette entry: alpha/mode nibble on top of 4:4:4 rgb
    typedef logic [15:0] argb_t;
    // blended pixel colour
    typedef logic [11:0] rgb_t;
    // palette index
    typedef logic [7:0]  color_idx_t;
    // raster position, sized for the small frame below
    typedef logic [4:0]  pos_x_t;
    typedef logic [2:0]  pos_y_t;
    // host write bus
    typedef logic [9:0]  host_addr_t;
    typedef logic [15:0] host_data_t;

    // sync bits that travel together down the pipeline
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic dv_de;
    } video_sync_t;

    // playfield control word, host data bit 8 is the vertical flag
    typedef struct packed {
        logic       vertical;
        color_idx_t base;
    } pf_ctrl_t;

    // horizontal raster, in pixel clocks
    localparam int H_ACTIVE     = 16;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 2;
    localparam int H_BACK       = 4;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

    // vertical raster, in lines
    localparam int V_ACTIVE     = 4;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 1;
    localparam int V_BACK       = 2;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    localparam int PAL_DEPTH    = 256;

    // host address bits 9..8 select the write target
    localparam logic [1:0] TGT_PAL_A  = 2'd0;
    localparam logic [1:0] TGT_PAL_B  = 2'd1;
    localparam logic [1:0] TGT_CTRL_A = 2'd2;
    localparam logic [1:0] TGT_CTRL_B = 2'd3;

endpackage

/* video_timing.sv */
`default_nettype none
`timescale 1ns/1ps

module video_timing (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    output      video_pkg::video_sync_t sync_o,
    output      video_pkg::pos_x_t      pos_x_o,
    output      video_pkg::pos_y_t      pos_y_o
);
    import video_pkg::*;

    // free running raster counters
    pos_x_t      h_cnt;
    pos_y_t      v_cnt;
    logic        h_last;
    logic        v_last;
    // sync levels decoded from the current counter state
    video_sync_t sync_dec;

    assign h_last = (h_cnt == pos_x_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == pos_y_t'(V_TOTAL - 1));

    always_comb begin
        // hsync window sits after the front porch of each line
        sync_dec.hsync = (h_cnt >= pos_x_t'(H_SYNC_START)) &&
                         (h_cnt <  pos_x_t'(H_SYNC_END));
        // vsync window covers whole lines after the vertical front porch
        sync_dec.vsync = (v_cnt >= pos_y_t'(V_SYNC_START)) &&
                         (v_cnt <  pos_y_t'(V_SYNC_END));
        // visible only in the top left active region
        sync_dec.dv_de = (h_cnt < pos_x_t'(H_ACTIVE)) &&
                         (v_cnt < pos_y_t'(V_ACTIVE));
    end

    // counters step every clock, vertical steps at end of line
    always_ff @(posedge clk) begin
        if (rst_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // position and sync leave together, one register stage after the counters
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sync_o  <= '0;
            pos_x_o <= '0;
            pos_y_o <= '0;
        end else begin
            sync_o  <= sync_dec;
            pos_x_o <= h_cnt;
            pos_y_o <= v_cnt;
        end
    end

endmodule
`default_nettype wire

/* video_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module video_regs (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    input  wire logic                  host_wr_i,
    input  wire video_pkg::host_addr_t host_addr_i,
    input  wire video_pkg::host_data_t host_data_i,
    output      logic                  pal_a_wr_o,
    output      logic                  pal_b_wr_o,
    output      video_pkg::color_idx_t pal_idx_o,
    output      video_pkg::argb_t      pal_data_o,
    output      video_pkg::pf_ctrl_t   ctrl_a_o,
    output      video_pkg::pf_ctrl_t   ctrl_b_o
);
    import video_pkg::*;

    // target field of the host address
    logic [1:0] tgt;
    logic       ctrl_a_wr;
    logic       ctrl_b_wr;

    assign tgt = host_addr_i[9:8];

    // palette strobes go straight to the RAM write port
    // so the entry is readable on the next cycle
    assign pal_a_wr_o = host_wr_i && (tgt == TGT_PAL_A);
    assign pal_b_wr_o = host_wr_i && (tgt == TGT_PAL_B);
    assign pal_idx_o  = host_addr_i[7:0];
    assign pal_data_o = host_data_i;

    assign ctrl_a_wr  = host_wr_i && (tgt == TGT_CTRL_A);
    assign ctrl_b_wr  = host_wr_i && (tgt == TGT_CTRL_B);

    // control words, low 9 data bits hold vertical flag and base
    always_ff @(posedge clk) begin
        if (rst_i) begin
            // base 0, index follows x
            ctrl_a_o <= '0;
            ctrl_b_o <= '0;
        end else begin
            if (ctrl_a_wr) begin
                ctrl_a_o <= pf_ctrl_t'(host_data_i[8:0]);
            end
            if (ctrl_b_wr) begin
                ctrl_b_o <= pf_ctrl_t'(host_data_i[8:0]);
            end
        end
    end

endmodule
`default_nettype wire

/* playfield_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module playfield_gen (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire video_pkg::video_sync_t sync_i,
    input  wire video_pkg::pos_x_t      pos_x_i,
    input  wire video_pkg::pos_y_t      pos_y_i,
    input  wire video_pkg::pf_ctrl_t    ctrl_i,
    output      video_pkg::video_sync_t sync_o,
    output      video_pkg::color_idx_t  idx_o
);
    import video_pkg::*;

    // position term zero extended to index width
    color_idx_t pos_sel;
    color_idx_t idx_next;

    always_comb begin
        if (ctrl_i.vertical) begin
            pos_sel = {{($bits(color_idx_t) - $bits(pos_y_t)){1'b0}}, pos_y_i};
        end else begin
            pos_sel = {{($bits(color_idx_t) - $bits(pos_x_t)){1'b0}}, pos_x_i};
        end
        // wraps modulo 256
        idx_next = ctrl_i.base + pos_sel;
    end

    // registered palette index
    always_ff @(posedge clk) begin
        idx_o <= idx_next;
    end

    // sync follows the index by the same one cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sync_o <= '0;
        end else begin
            sync_o <= sync_i;
        end
    end

endmodule
`default_nettype wire

/* color_lut.sv */
`default_nettype none
`timescale 1ns/1ps

module color_lut (
    input  wire logic                  clk,
    input  wire logic                  wr_i,
    input  wire video_pkg::color_idx_t wr_idx_i,
    input  wire video_pkg::argb_t      wr_data_i,
    input  wire video_pkg::color_idx_t rd_idx_i,
    output      video_pkg::argb_t      rd_data_o
);
    import video_pkg::*;

    // palette storage, maps to one block RAM
    argb_t mem [PAL_DEPTH];

    // host write port
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // video read port, one cycle latency
    // a write on the same edge shows up from the next read
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_idx_i];
    end

endmodule
`default_nettype wire

/* video_blend.sv */
`default_nettype none
`timescale 1ns/1ps

module video_blend (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire video_pkg::video_sync_t sync_i,
    input  wire video_pkg::argb_t       color_a_i,
    input  wire video_pkg::argb_t       color_b_i,
    output      video_pkg::video_sync_t sync_o,
    output      video_pkg::rgb_t        rgb_o
);
    import video_pkg::*;

    // sync delayed one cycle to line up with the palette data
    video_sync_t sync_d1;
    // A bit 15 picks alpha or blend family, B bits 15..14 pick the op
    logic [2:0]  mode;
    rgb_t        blend_rgb;

    // one 4-bit channel, A is the lower playfield and B sits on top
    function automatic logic [3:0] blend_chan(
        input logic [2:0] m,
        input logic [3:0] a,
        input logic [3:0] b
    );
        logic [4:0] sum;
        logic [4:0] diff;
        logic [5:0] a75;
        logic [5:0] dbl;
        logic [3:0] res;
        sum  = {1'b0, a} + {1'b0, b};
        diff = {1'b0, a} - {1'b0, b};
        // a + 2a + b, top bits give (3a + b) / 4
        a75  = {2'b00, a} + {1'b0, a, 1'b0} + {2'b00, b};
        // a + 2b, unsigned view of the doubled delta
        dbl  = {2'b00, a} + {1'b0, b, 1'b0};
        case (m)
            // alpha family
            3'b0_00: res = a;
            3'b0_01: res = a75[5:2];
            3'b0_10: res = sum[4:1];
            3'b0_11: res = b;
            // additive, saturate at F
            3'b1_00: res = sum[4] ? 4'hF : sum[3:0];
            // subtractive, borrow means below zero
            3'b1_01: res = diff[4] ? 4'h0 : diff[3:0];
            // signed delta -8..+7
            // negative b: no carry means the true result went below zero
            3'b1_10: begin
                if (b[3]) begin
                    res = sum[4] ? sum[3:0] : 4'h0;
                end else begin
                    res = sum[4] ? 4'hF : sum[3:0];
                end
            end
            // doubled delta, negative b is 2b - 32 so bit 5 is the borrow
            default: begin
                if (b[3]) begin
                    res = dbl[5] ? dbl[3:0] : 4'h0;
                end else begin
                    res = dbl[4] ? 4'hF : dbl[3:0];
                end
            end
        endcase
        return res;
    endfunction

    assign mode = {color_a_i[15], color_b_i[15:14]};

    always_comb begin
        // red, green, blue handled alike
        blend_rgb[11:8] = blend_chan(mode, color_a_i[11:8], color_b_i[11:8]);
        blend_rgb[7:4]  = blend_chan(mode, color_a_i[7:4],  color_b_i[7:4]);
        blend_rgb[3:0]  = blend_chan(mode, color_a_i[3:0],  color_b_i[3:0]);
    end

    // second stage registers colour and sync together
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sync_d1 <= '0;
            sync_o  <= '0;
            rgb_o   <= '0;
        end else begin
            sync_d1 <= sync_i;
            sync_o  <= sync_d1;
            // black outside the visible area
            if (sync_d1.dv_de) begin
                rgb_o <= blend_rgb;
            end else begin
                rgb_o <= '0;
            end
        end
    end

endmodule
`default_nettype wire

/* video_top.sv */
`default_nettype none
`timescale 1ns/1ps

module video_top (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    input  wire logic                  host_wr_i,
    input  wire video_pkg::host_addr_t host_addr_i,
    input  wire video_pkg::host_data_t host_data_i,
    output      logic                  hsync_o,
    output      logic                  vsync_o,
    output      logic                  dv_de_o,
    output      video_pkg::rgb_t       rgb_o
);
    import video_pkg::*;

    // raster outputs
    video_sync_t tim_sync;
    pos_x_t      pos_x;
    pos_y_t      pos_y;

    // host side
    logic        pal_a_wr;
    logic        pal_b_wr;
    color_idx_t  pal_idx;
    argb_t       pal_data;
    pf_ctrl_t    ctrl_a;
    pf_ctrl_t    ctrl_b;

    // playfield indices and colours
    video_sync_t pf_a_sync;
    color_idx_t  idx_a;
    color_idx_t  idx_b;
    argb_t       color_a;
    argb_t       color_b;
    video_sync_t out_sync;

    video_timing u_timing (
        .clk     (clk),
        .rst_i   (rst_i),
        .sync_o  (tim_sync),
        .pos_x_o (pos_x),
        .pos_y_o (pos_y)
    );

    video_regs u_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .pal_a_wr_o  (pal_a_wr),
        .pal_b_wr_o  (pal_b_wr),
        .pal_idx_o   (pal_idx),
        .pal_data_o  (pal_data),
        .ctrl_a_o    (ctrl_a),
        .ctrl_b_o    (ctrl_b)
    );

    // playfield A also carries the sync for the blend stage
    playfield_gen u_pf_a (
        .clk     (clk),
        .rst_i   (rst_i),
        .sync_i  (tim_sync),
        .pos_x_i (pos_x),
        .pos_y_i (pos_y),
        .ctrl_i  (ctrl_a),
        .sync_o  (pf_a_sync),
        .idx_o   (idx_a)
    );

    // B runs in lockstep with A, its sync copy is left open
    playfield_gen u_pf_b (
        .clk     (clk),
        .rst_i   (rst_i),
        .sync_i  (tim_sync),
        .pos_x_i (pos_x),
        .pos_y_i (pos_y),
        .ctrl_i  (ctrl_b),
        .sync_o  (),
        .idx_o   (idx_b)
    );

    color_lut u_lut_a (
        .clk       (clk),
        .wr_i      (pal_a_wr),
        .wr_idx_i  (pal_idx),
        .wr_data_i (pal_data),
        .rd_idx_i  (idx_a),
        .rd_data_o (color_a)
    );

    color_lut u_lut_b (
        .clk       (clk),
        .wr_i      (pal_b_wr),
        .wr_idx_i  (pal_idx),
        .wr_data_i (pal_data),
        .rd_idx_i  (idx_b),
        .rd_data_o (color_b)
    );

    // sync enters with the index, colours arrive one cycle later
    video_blend u_blend (
        .clk       (clk),
        .rst_i     (rst_i),
        .sync_i    (pf_a_sync),
        .color_a_i (color_a),
        .color_b_i (color_b),
        .sync_o    (out_sync),
        .rgb_o     (rgb_o)
    );

    assign hsync_o = out_sync.hsync;
    assign vsync_o = out_sync.vsync;
    assign dv_de_o = out_sync.dv_de;

endmodule
`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    // 10 ns period, first rising edge at 5 ns
    localparam time HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

/* video_top_tb.sv */
`timescale 1ns/1ps

module video_top_tb;
    import video_pkg::*;

    localparam int          NUM_ROWS    = 10;
    localparam int          NUM_PAL     = 20;
    localparam int          FRAME_PIX   = H_ACTIVE * V_ACTIVE;
    localparam int          TIMEOUT_CYC = (NUM_ROWS + 2) * 3 * H_TOTAL * V_TOTAL + 200;
    localparam logic [31:0] LFSR_SEED   = 32'h3db4_3e72;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    // fixed colours, control words, random flag and expected pixel
    typedef struct packed {
        argb_t    col_a;
        argb_t    col_b;
        pf_ctrl_t ctrl_a;
        pf_ctrl_t ctrl_b;
        logic     rnd;
        rgb_t     exp_rgb;
    } test_row_t;

    logic        clk;
    logic        rst_i;
    logic        host_wr_i;
    host_addr_t  host_addr_i;
    host_data_t  host_data_i;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;
    rgb_t        rgb_o;

    test_row_t   rows [NUM_ROWS];
    // copies of what was written to palette entries 0..19
    argb_t       pal_a [NUM_PAL];
    argb_t       pal_b [NUM_PAL];
    logic [31:0] lfsr;
    int          cyc = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          total_errs = 0;
    // blanking and frame monitor state
    int          mon_errs = 0;
    int          frames_seen = 0;
    int          de_cnt = 0;
    int          hs_cnt = 0;
    int          hs_len = 0;
    logic        in_frame = 1'b0;
    logic        vs_prev = 1'b0;
    logic        hs_prev = 1'b0;

    tb_clock u_clock (.clk(clk));

    video_top UUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .dv_de_o     (dv_de_o),
        .rgb_o       (rgb_o)
    );

    // 16 bits from the galois lfsr with one step per bit
    function automatic argb_t rand_word();
        argb_t w;
        logic  b;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? LFSR_TAPS : 32'h0);
            w    = {w[14:0], b};
        end
        return w;
    endfunction

    // blend rule in plain integers then clamped to 0..F
    function automatic rgb_t ref_blend(input argb_t a, input argb_t b);
        int   ca;
        int   cb;
        int   sb;
        int   r;
        rgb_t res;
        res = '0;
        for (int ch = 0; ch < 3; ch++) begin
            ca = int'(a[4*ch +: 4]);
            cb = int'(b[4*ch +: 4]);
            // B as a signed nibble for the delta modes
            sb = (cb >= 8) ? cb - 16 : cb;
            case ({a[15], b[15:14]})
                3'd0:    r = ca;
                3'd1:    r = (3 * ca + cb) / 4;
                3'd2:    r = (ca + cb) / 2;
                3'd3:    r = cb;
                3'd4:    r = ca + cb;
                3'd5:    r = ca - cb;
                3'd6:    r = ca + sb;
                default: r = ca + 2 * sb;
            endcase
            r = (r > 15) ? 15 : ((r < 0) ? 0 : r);
            res[4*ch +: 4] = r[3:0];
        end
        return res;
    endfunction

    task automatic report_test(input string name, input int errs);
        tests_run++;
        total_errs += errs;
        if (errs == 0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
        end
    endtask

    task automatic host_write(input host_addr_t addr, input host_data_t data);
        @(posedge clk);
        host_wr_i   <= 1'b1;
        host_addr_i <= addr;
        host_data_i <= data;
    endtask

    task automatic expect_low(input string name, input logic v, inout int errs);
        if (v !== 1'b0) begin
            $display("FAIL %s near reset: got %h expected 0", name, v);
            errs++;
        end
    endtask

    // reset for 4 cycles while outputs stay low until the pipeline fills
    task automatic reset_check();
        int errs;
        errs = 0;
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            if (i == 3) begin
                rst_i <= 1'b0;
            end
            @(negedge clk);
            expect_low("hsync_o", hsync_o, errs);
            expect_low("vsync_o", vsync_o, errs);
            expect_low("dv_de_o", dv_de_o, errs);
        end
        report_test("reset and blanking", errs);
    endtask

    task automatic run_row(input int r);
        test_row_t row;
        int        errs;
        int        x;
        int        y;
        int        ia;
        int        ib;
        rgb_t      exp_rgb;
        row  = rows[r];
        errs = 0;
        for (int e = 0; e < NUM_PAL; e++) begin
            pal_a[e] = row.rnd ? rand_word() : row.col_a;
            pal_b[e] = row.rnd ? rand_word() : row.col_b;
            host_write({TGT_PAL_A, 8'(e)}, pal_a[e]);
            host_write({TGT_PAL_B, 8'(e)}, pal_b[e]);
        end
        host_write({TGT_CTRL_A, 8'h00}, {7'b0, row.ctrl_a});
        host_write({TGT_CTRL_B, 8'h00}, {7'b0, row.ctrl_b});
        @(posedge clk);
        host_wr_i <= 1'b0;
        // the frame after the next vsync rise is collected
        @(negedge clk);
        while (vsync_o !== 1'b0) begin
            @(negedge clk);
        end
        while (vsync_o !== 1'b1) begin
            @(negedge clk);
        end
        for (int k = 0; k < FRAME_PIX; k++) begin
            @(negedge clk);
            while (dv_de_o !== 1'b1) begin
                @(negedge clk);
            end
            x  = k % H_ACTIVE;
            y  = k / H_ACTIVE;
            ia = (int'(row.ctrl_a.base) + (row.ctrl_a.vertical ? y : x)) % PAL_DEPTH;
            ib = (int'(row.ctrl_b.base) + (row.ctrl_b.vertical ? y : x)) % PAL_DEPTH;
            if (row.rnd && (ia >= NUM_PAL || ib >= NUM_PAL)) begin
                $display("pixel %0d of row %0d reads a palette entry that was never written",
                         k, r);
                errs++;
            end else begin
                exp_rgb = row.rnd ? ref_blend(pal_a[ia], pal_b[ib]) : row.exp_rgb;
                if (rgb_o !== exp_rgb) begin
                    $display("FAIL rgb_o row %0d x=%0d y=%0d: got %03h expected %03h",
                             r, x, y, rgb_o, exp_rgb);
                    errs++;
                end
            end
        end
        report_test($sformatf("table row %0d", r), errs);
    endtask

    // blanking and frame structure sampled on the falling edge
    always @(negedge clk) begin
        if (cyc > 0) begin
            if (dv_de_o === 1'b0 && rgb_o !== '0) begin
                $display("FAIL rgb_o with dv_de_o low at cycle %0d: got %03h expected 000",
                         cyc, rgb_o);
                mon_errs++;
            end
            if (vsync_o === 1'b1 && vs_prev === 1'b0) begin
                if (in_frame && (de_cnt != FRAME_PIX || hs_cnt != V_TOTAL)) begin
                    $display("FAIL dv_de_o/hsync_o per frame: got %0h/%0h expected %0h/%0h",
                             de_cnt, hs_cnt, FRAME_PIX, V_TOTAL);
                    mon_errs++;
                end
                frames_seen += in_frame ? 1 : 0;
                in_frame = 1'b1;
                de_cnt   = 0;
                hs_cnt   = 0;
            end
            if (in_frame) begin
                de_cnt += (dv_de_o === 1'b1) ? 1 : 0;
                if (hsync_o === 1'b1 && hs_prev === 1'b0) begin
                    hs_cnt++;
                    hs_len = 0;
                end
                hs_len += (hsync_o === 1'b1) ? 1 : 0;
                if (hsync_o === 1'b0 && hs_prev === 1'b1 && hs_len != H_SYNC) begin
                    $display("FAIL hsync_o pulse width: got %0h expected %0h", hs_len, H_SYNC);
                    mon_errs++;
                end
            end
            vs_prev = vsync_o;
            hs_prev = hsync_o;
        end
    end

    // cycle limit scaled from the number of table rows
    always @(posedge clk) begin
        cyc++;
        if (cyc >= TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int errs;
        rst_i       = 1'b1;
        host_wr_i   = 1'b0;
        host_addr_i = '0;
        host_data_i = '0;
        lfsr        = LFSR_SEED;
        // alpha family with A bit 15 clear
        rows[0] = '{16'h05A3, 16'h0C1F, 9'h000, 9'h000, 1'b0, 12'h5A3};
        rows[1] = '{16'h084C, 16'h4F04, 9'h000, 9'h000, 1'b0, 12'h93A};
        rows[2] = '{16'h039F, 16'h8621, 9'h000, 9'h000, 1'b0, 12'h458};
        rows[3] = '{16'h0123, 16'hCABC, 9'h000, 9'h000, 1'b0, 12'hABC};
        // clamped family hitting F and 0 with positive and negative B
        rows[4] = '{16'h892F, 16'h0931, 9'h000, 9'h000, 1'b0, 12'hF5F};
        rows[5] = '{16'h85E2, 16'h4732, 9'h000, 9'h000, 1'b0, 12'h0B0};
        rows[6] = '{16'h8E37, 16'h8592, 9'h000, 9'h000, 1'b0, 12'hF09};
        rows[7] = '{16'h8A28, 16'hC4ED, 9'h000, 9'h000, 1'b0, 12'hF02};
        // random palettes whose bases keep every index inside entries 0..19
        rows[8] = '{16'h0000, 16'h0000, 9'h003, 9'h10C, 1'b1, 12'h000};
        rows[9] = '{16'h0000, 16'h0000, 9'h110, 9'h004, 1'b1, 12'h000};
        reset_check();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        errs = mon_errs;
        if (frames_seen == 0) begin
            $display("no complete frame was seen between two vsync pulses");
            errs++;
        end
        report_test("blanking and frame structure", errs);
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
video_pkg.sv
video_timing.sv
video_regs.sv
playfield_gen.sv
color_lut.sv
video_blend.sv
video_top.sv
tb_clock.sv
video_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module video_top_tb -f compile.f -o sim_video_top

./obj_dir/sim_video_top > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"
